// ==== filelist.f ====
design/gpio_pkg.sv
design/gpio_apb_regs.sv
design/gpio_input_monitor.sv
design/gpio_top.sv
tests/tb_gpio.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
mkdir -p build
verilator --binary --timing --assert -Wno-fatal --top-module tb_gpio \
   -f filelist.f --Mdir build -o sim_gpio > build/build.log 2>&1 \
   && ./build/sim_gpio > sim.log 2>&1 \
   || { echo "build or run failed"; tail -n 20 build/build.log; }
grep -q "SIMULATION PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// ==== tests/tb_gpio.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gpio
   import gpio_pkg::*;
();

   localparam int NUM_TESTS   = 6;
   localparam int WATCHDOG_NS = NUM_TESTS * 400 * 100;

   logic        PCLK;
   logic        aresetn;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [7:0]  gpio_in;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic [7:0]  int_vec;
   logic        int_or;
   logic [7:0]  gpio_out;
   logic [7:0]  gpio_oe;

   logic [31:0] lfsr_q = 32'hdf70;
   string       cur_test = "";
   int          test_errs = 0;
   int          total_errs = 0;
   int          checks = 0;
   int          tests_done = 0;
   logic [7:0]  cfg_m [8];
   logic [2:0]  edge_typ;
   int          edge_pin;
   logic        pin_lvl;
   logic        latch_m;

   gpio_top #(
      .IO_NUM (8),
      .IO_VAL (32'h0000_00A5)
   ) i_gpio_top (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .psel_i     (psel),
      .penable_i  (penable),
      .pwrite_i   (pwrite),
      .paddr_i    (paddr),
      .pwdata_i   (pwdata),
      .gpio_in_i  (gpio_in),
      .prdata_o   (prdata),
      .pready_o   (pready),
      .pslverr_o  (pslverr),
      .int_o      (int_vec),
      .int_or_o   (int_or),
      .gpio_out_o (gpio_out),
      .gpio_oe_o  (gpio_oe)
   );

   initial PCLK = 1'b0;
   always #50 PCLK = ~PCLK;

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------
   // galois lfsr on x^32+x^22+x^2+x+1 with one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
         r = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   // config word with input enabled and the other enables off
   function automatic logic [31:0] cfg_word(input logic [2:0] typ, input logic ien);
      pin_cfg_t c;
      c = '0;
      c.int_type = typ;
      c.int_en   = ien;
      c.in_en    = 1'b1;
      return {24'h0, c};
   endfunction

   // one enable bit gathered across the eight model bytes
   function automatic logic [7:0] cfg_bits(input int b);
      logic [7:0] r;
      for (int i = 0; i < 8; i++)
         r[i] = cfg_m[i][b];
      return r;
   endfunction

   task automatic expect_eq(input string what, input logic [31:0] exp,
                            input logic [31:0] act);
      checks++;
      assert (act === exp)
      else
      begin
         $display("MISMATCH %s: %s expected %h actual %h", cur_test, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      @(posedge PCLK);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge PCLK);
      penable <= 1'b1;
      @(posedge PCLK);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
      @(posedge PCLK);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge PCLK);
      penable <= 1'b1;
      @(negedge PCLK);
      data = prdata;
      @(posedge PCLK);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic check_read(input logic [7:0] addr, input logic [31:0] exp);
      logic [31:0] d;
      read_reg(addr, d);
      expect_eq($sformatf("read %h", addr), exp, d);
   endtask

   task automatic drive_pins(input logic [7:0] value);
      @(posedge PCLK);
      gpio_in <= value;
   endtask

   // past the three sync flops and sampled mid-cycle
   task automatic settle();
      repeat (4) @(posedge PCLK);
      @(negedge PCLK);
   endtask

   task automatic write_random_cfg();
      logic [31:0] w;
      for (int i = 0; i < 8; i++)
      begin
         w = rand_bits(32);
         cfg_m[i] = w[7:0];
         write_reg(8'(4 * i), w);
      end
   endtask

   // flip the watched pin and check int_o against the latch model
   task automatic toggle_pin();
      logic nl;
      nl = ~pin_lvl;
      drive_pins(8'(nl) << edge_pin);
      settle();
      if (edge_typ == INT_EDGE_BOTH || (edge_typ == INT_EDGE_POS && nl) ||
          (edge_typ == INT_EDGE_NEG && !nl))
         latch_m = 1'b1;
      pin_lvl = nl;
      expect_eq("int_o after edge", 32'(latch_m) << edge_pin, 32'(int_vec));
      // only the watched pin has int_en set
      expect_eq("int_or_o after edge", 32'(latch_m), 32'(int_or));
   endtask

   task automatic end_test();
      if (test_errs == 0)
         $display("test %s done, no errors", cur_test);
      else
         $display("test %s done, %0d errors", cur_test, test_errs);
      total_errs += test_errs;
      test_errs = 0;
      tests_done++;
   endtask

   // zero wait states and no error response in every cycle
   a_bus_resp: assert property (@(posedge PCLK) disable iff (!aresetn)
      pready && !pslverr)
   else
   begin
      $display("MISMATCH %s: ready/err expected 1/0 actual %b/%b", cur_test, pready, pslverr);
      test_errs++;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
      $display("SIMULATION FAILED");
      $finish;
   end

   // ----------------------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------------------
   initial
   begin
      logic [31:0] v;
      logic [31:0] w;
      logic [31:0] gpout_m;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= '0;
      pwdata  <= '0;
      gpio_in <= '0;
      aresetn <= 1'b0;
      repeat (2) @(posedge PCLK);
      aresetn <= 1'b1;

      cur_test = "reset";
      settle();
      expect_eq("gpio_out_o", 32'h0, 32'(gpio_out));
      expect_eq("gpio_oe_o", 32'h0, 32'(gpio_oe));
      expect_eq("int_o", 32'h0, 32'(int_vec));
      expect_eq("int_or_o", 32'h0, 32'(int_or));
      expect_eq("pready_o", 32'h1, 32'(pready));
      for (int i = 0; i < 8; i++)
         check_read(8'(4 * i), 32'h0);
      check_read(ADDR_GPOUT, 32'hA5);
      end_test();

      cur_test = "cfg_rdback";
      write_random_cfg();
      for (int i = 0; i < 8; i++)
         check_read(8'(4 * i), {24'h0, cfg_m[i]});
      for (int a = 8'h20; a < 8'h80; a += 4)
         check_read(8'(a), 32'h0);
      check_read(8'h84, 32'h0);
      check_read(8'h94, 32'h0);
      check_read(8'hB0, 32'h0);
      check_read(8'hFC, 32'h0);
      end_test();

      cur_test = "output_drive";
      for (int r = 0; r < 3; r++)
      begin
         gpout_m = rand_bits(32);
         write_reg(ADDR_GPOUT, gpout_m);
         write_random_cfg();
         settle();
         expect_eq("gpio_out_o", {24'h0, gpout_m[7:0] & cfg_bits(0)}, 32'(gpio_out));
         expect_eq("gpio_oe_o", {24'h0, cfg_bits(2) & cfg_bits(0)}, 32'(gpio_oe));
         check_read(ADDR_GPOUT, {24'h0, gpout_m[7:0]});
      end
      end_test();

      cur_test = "input_rdback";
      for (int r = 0; r < 3; r++)
      begin
         write_random_cfg();
         w = rand_bits(8);
         drive_pins(w[7:0]);
         settle();
         check_read(ADDR_GPIN, {24'h0, w[7:0] & cfg_bits(1)});
      end
      end_test();

      cur_test = "level_int";
      v = rand_bits(8);
      for (int i = 0; i < 8; i++)
         write_reg(8'(4 * i), cfg_word({2'b00, v[i]}, 1'b1));
      for (int r = 0; r < 3; r++)
      begin
         w = rand_bits(8);
         drive_pins(w[7:0]);
         settle();
         // level low pins show the inverse
         expect_eq("int_o", {24'h0, w[7:0] ^ v[7:0]}, 32'(int_vec));
         expect_eq("int_or_o", 32'(|(w[7:0] ^ v[7:0])), 32'(int_or));
         check_read(ADDR_INTR, {24'h0, w[7:0] ^ v[7:0]});
         write_reg(ADDR_INTR, 32'hFF);
         settle();
         check_read(ADDR_INTR, {24'h0, w[7:0] ^ v[7:0]});
      end
      end_test();

      cur_test = "edge_int";
      for (int k = 0; k < 3; k++)
      begin
         edge_typ = 3'(int'(INT_EDGE_POS) + k);
         edge_pin = int'(rand_bits(3));
         // rising type starts high so its first toggle is a fall
         pin_lvl  = (edge_typ == INT_EDGE_POS);
         latch_m  = 1'b0;
         for (int i = 0; i < 8; i++)
            write_reg(8'(4 * i), 32'h0);
         drive_pins(8'(pin_lvl) << edge_pin);
         settle();
         write_reg(8'(4 * edge_pin), cfg_word(edge_typ, 1'b1));
         settle();
         expect_eq("int_o idle", 32'h0, 32'(int_vec));
         repeat (3) toggle_pin();
         check_read(ADDR_INTR, 32'(latch_m) << edge_pin);
         write_reg(ADDR_INTR, 32'h1 << edge_pin);
         latch_m = 1'b0;
         settle();
         expect_eq("int_o after clear", 32'h0, 32'(int_vec));
         expect_eq("int_or_o after clear", 32'h0, 32'(int_or));
         check_read(ADDR_INTR, 32'h0);
         toggle_pin();
         write_reg(8'(4 * edge_pin), cfg_word(edge_typ, 1'b0));
         write_reg(8'(4 * edge_pin), cfg_word(edge_typ, 1'b1));
         latch_m = 1'b0;
         settle();
         expect_eq("int_o after int_en off", 32'h0, 32'(int_vec));
         expect_eq("int_or_o after int_en off", 32'h0, 32'(int_or));
      end
      end_test();

      $display("tests %0d of %0d, checks %0d, errors %0d",
               tests_done, NUM_TESTS, checks, total_errs);
      if (total_errs == 0 && tests_done == NUM_TESTS)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/gpio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_top
   import gpio_pkg::*;
#(
   parameter int                IO_NUM = 32,
   parameter logic [MAX_IO-1:0] IO_VAL = '0
)
(
   input  wire                    PCLK,
   input  wire                    aresetn,
   input  wire                    psel_i,
   input  wire                    penable_i,
   input  wire                    pwrite_i,
   input  wire  [APB_ADDR_W-1:0]  paddr_i,
   input  wire  [APB_DATA_W-1:0]  pwdata_i,
   input  wire  [IO_NUM-1:0]      gpio_in_i,
   output logic [APB_DATA_W-1:0]  prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   output logic [IO_NUM-1:0]      int_o,
   output logic                   int_or_o,
   output logic [IO_NUM-1:0]      gpio_out_o,
   output logic [IO_NUM-1:0]      gpio_oe_o
);

   apb_req_t              apb_req;
   pin_cfg_t [IO_NUM-1:0] pin_cfg;
   irq_clr_t              irq_clr;
   logic [IO_NUM-1:0]     pin_level;
   logic [IO_NUM-1:0]     irq_status;

   assign apb_req.psel    = psel_i;
   assign apb_req.penable = penable_i;
   assign apb_req.pwrite  = pwrite_i;
   assign apb_req.paddr   = paddr_i;
   assign apb_req.pwdata  = pwdata_i;

   // zero wait states, never an error
   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   gpio_apb_regs #(
      .IO_NUM (IO_NUM),
      .IO_VAL (IO_VAL)
   ) i_regs (
      .PCLK         (PCLK),
      .aresetn      (aresetn),
      .apb_i        (apb_req),
      .pin_level_i  (pin_level),
      .irq_status_i (irq_status),
      .prdata_o     (prdata_o),
      .pin_cfg_o    (pin_cfg),
      .irq_clr_o    (irq_clr),
      .gpio_out_o   (gpio_out_o),
      .gpio_oe_o    (gpio_oe_o)
   );

   gpio_input_monitor #(
      .IO_NUM (IO_NUM)
   ) i_monitor (
      .PCLK         (PCLK),
      .aresetn      (aresetn),
      .gpio_in_i    (gpio_in_i),
      .pin_cfg_i    (pin_cfg),
      .irq_clr_i    (irq_clr),
      .pin_level_o  (pin_level),
      .irq_status_o (irq_status),
      .int_o        (int_o),
      .int_or_o     (int_or_o)
   );

endmodule

`default_nettype wire

// ==== design/gpio_input_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_input_monitor
   import gpio_pkg::*;
#(
   parameter int IO_NUM = 32
)
(
   input  wire                    PCLK,
   input  wire                    aresetn,
   input  wire  [IO_NUM-1:0]      gpio_in_i,
   input  pin_cfg_t [IO_NUM-1:0]  pin_cfg_i,
   input  irq_clr_t               irq_clr_i,
   output logic [IO_NUM-1:0]      pin_level_o,
   output logic [IO_NUM-1:0]      irq_status_o,
   output logic [IO_NUM-1:0]      int_o,
   output logic                   int_or_o
);

   logic [IO_NUM-1:0] sync1_q;
   logic [IO_NUM-1:0] sync2_q;
   logic [IO_NUM-1:0] level_q;
   logic [IO_NUM-1:0] edge_pos_q;
   logic [IO_NUM-1:0] edge_neg_q;
   logic [IO_NUM-1:0] edge_both_q;
   logic [IO_NUM-1:0] status_q;
   logic [IO_NUM-1:0] rise;
   logic [IO_NUM-1:0] fall;
   logic [IO_NUM-1:0] clr_hit;
   logic [IO_NUM-1:0] int_en_v;
   logic [IO_NUM-1:0] int_src;

   // ----------------------------------------------------------------------
   // three-flop input synchronizer
   // ----------------------------------------------------------------------
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         sync1_q <= '0;
         sync2_q <= '0;
         level_q <= '0;
      end
      else
      begin
         sync1_q <= gpio_in_i;
         sync2_q <= sync1_q;
         level_q <= sync2_q;
      end
   end

   assign pin_level_o = level_q;

   // edges seen as level_q is about to take the new value
   assign rise    = sync2_q & ~level_q;
   assign fall    = ~sync2_q & level_q;
   assign clr_hit = irq_clr_i.strobe ? irq_clr_i.mask[IO_NUM-1:0] : '0;

   always_comb
   begin
      for (int i = 0; i < IO_NUM; i++)
      begin
         int_en_v[i] = pin_cfg_i[i].int_en;
      end
   end

   // ----------------------------------------------------------------------
   // sticky edge latches
   // ----------------------------------------------------------------------
   // a new edge beats a clear in the same cycle
   // int_en low empties all three
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         edge_pos_q  <= '0;
         edge_neg_q  <= '0;
         edge_both_q <= '0;
      end
      else
      begin
         edge_pos_q  <= int_en_v & (rise | (edge_pos_q & ~clr_hit));
         edge_neg_q  <= int_en_v & (fall | (edge_neg_q & ~clr_hit));
         edge_both_q <= int_en_v & (rise | fall | (edge_both_q & ~clr_hit));
      end
   end

   // source select per pin
   always_comb
   begin
      for (int i = 0; i < IO_NUM; i++)
      begin
         case (pin_cfg_i[i].int_type)
            INT_LEVEL_HIGH: int_src[i] = level_q[i];
            INT_LEVEL_LOW:  int_src[i] = ~level_q[i];
            INT_EDGE_POS:   int_src[i] = edge_pos_q[i];
            INT_EDGE_NEG:   int_src[i] = edge_neg_q[i];
            INT_EDGE_BOTH:  int_src[i] = edge_both_q[i];
            default:        int_src[i] = 1'b0;
         endcase
      end
   end

   assign int_o    = int_src & int_en_v;
   assign int_or_o = |int_o;

   // ----------------------------------------------------------------------
   // interrupt status follows int_o one cycle late
   // ----------------------------------------------------------------------
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         status_q <= '0;
      end
      else if (irq_clr_i.strobe)
      begin
         status_q <= status_q & ~irq_clr_i.mask[IO_NUM-1:0];
      end
      else
      begin
         status_q <= int_o;
      end
   end

   assign irq_status_o = status_q;

   // the any-edge latch covers both single-edge latches
   a_both_covers: assert property (
      @(posedge PCLK) disable iff (!aresetn)
      ((edge_pos_q | edge_neg_q) & ~edge_both_q) == '0
   );

endmodule

`default_nettype wire

// ==== design/gpio_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_apb_regs
   import gpio_pkg::*;
#(
   parameter int                IO_NUM = 32,
   parameter logic [MAX_IO-1:0] IO_VAL = '0
)
(
   input  wire                    PCLK,
   input  wire                    aresetn,
   input  apb_req_t               apb_i,
   input  wire  [IO_NUM-1:0]      pin_level_i,
   input  wire  [IO_NUM-1:0]      irq_status_i,
   output logic [APB_DATA_W-1:0]  prdata_o,
   output pin_cfg_t [IO_NUM-1:0]  pin_cfg_o,
   output irq_clr_t               irq_clr_o,
   output logic [IO_NUM-1:0]      gpio_out_o,
   output logic [IO_NUM-1:0]      gpio_oe_o
);

   pin_cfg_t [IO_NUM-1:0] cfg_q;
   logic [IO_NUM-1:0]     gpout_q;
   logic [IO_NUM-1:0]     out_en_v;
   logic [IO_NUM-1:0]     oe_en_v;
   logic [IO_NUM-1:0]     in_en_v;
   logic [5:0]            slot;
   logic                  wr_en;
   logic                  cfg_wr;

   // ----------------------------------------------------------------------
   // write decode
   // ----------------------------------------------------------------------
   assign wr_en  = apb_i.psel & apb_i.penable & apb_i.pwrite;
   assign cfg_wr = wr_en & (apb_i.paddr < ADDR_CFG_LIMIT);
   assign slot   = apb_i.paddr[7:2];

   // one-cycle clear request with its mask straight from the write data
   assign irq_clr_o.strobe = wr_en & (apb_i.paddr == ADDR_INTR);
   assign irq_clr_o.mask   = apb_i.pwdata[MAX_IO-1:0];

   // configuration bytes in one word slot per pin
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         cfg_q <= '0;
      end
      else
      begin
         for (int i = 0; i < IO_NUM; i++)
         begin
            if (cfg_wr && (int'(slot) == i))
            begin
               cfg_q[i] <= apb_i.pwdata[7:0];
            end
         end
      end
   end

   // output register
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         gpout_q <= IO_VAL[IO_NUM-1:0];
      end
      else if (wr_en && (apb_i.paddr == ADDR_GPOUT))
      begin
         gpout_q <= apb_i.pwdata[IO_NUM-1:0];
      end
   end

   assign pin_cfg_o = cfg_q;

   // ----------------------------------------------------------------------
   // pin drive gating
   // ----------------------------------------------------------------------
   always_comb
   begin
      for (int i = 0; i < IO_NUM; i++)
      begin
         out_en_v[i] = cfg_q[i].out_en;
         oe_en_v[i]  = cfg_q[i].oe_en;
         in_en_v[i]  = cfg_q[i].in_en;
      end
   end

   assign gpio_out_o = gpout_q & out_en_v;
   // oe only when the output path itself is enabled
   assign gpio_oe_o  = oe_en_v & out_en_v;

   // ----------------------------------------------------------------------
   // read data mux driven straight from paddr
   // ----------------------------------------------------------------------
   always_comb
   begin
      prdata_o = '0;
      if (apb_i.paddr < ADDR_CFG_LIMIT)
      begin
         if (int'(slot) < IO_NUM)
         begin
            prdata_o = {{(APB_DATA_W-8){1'b0}}, cfg_q[slot]};
         end
      end
      else
      begin
         case (apb_i.paddr)
            ADDR_INTR:  prdata_o = APB_DATA_W'(irq_status_i);
            ADDR_GPIN:  prdata_o = APB_DATA_W'(pin_level_i & in_en_v);
            ADDR_GPOUT: prdata_o = APB_DATA_W'(gpout_q);
            default:    prdata_o = '0;
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------

   // a clear only comes out of a proper setup then access sequence
   a_clr_after_setup: assert property (
      @(posedge PCLK) disable iff (!aresetn)
      irq_clr_o.strobe |->
         $past(apb_i.psel && !apb_i.penable && apb_i.pwrite &&
               (apb_i.paddr == ADDR_INTR))
   );

endmodule

`default_nettype wire

// ==== design/gpio_pkg.sv ====
`default_nettype none

package gpio_pkg;

   // ----------------------------------------------------------------------
   // bus and pin sizing
   // ----------------------------------------------------------------------
   localparam int APB_DATA_W = 32;
   localparam int APB_ADDR_W = 8;
   localparam int MAX_IO     = 32;

   // register map
   localparam logic [APB_ADDR_W-1:0] ADDR_CFG_LIMIT = 8'h80;
   localparam logic [APB_ADDR_W-1:0] ADDR_INTR      = 8'h80;
   localparam logic [APB_ADDR_W-1:0] ADDR_GPIN      = 8'h90;
   localparam logic [APB_ADDR_W-1:0] ADDR_GPOUT     = 8'hA0;

   // interrupt type codes, codes 5..7 give no interrupt
   typedef enum logic [2:0] {
      INT_LEVEL_HIGH = 3'd0,
      INT_LEVEL_LOW  = 3'd1,
      INT_EDGE_POS   = 3'd2,
      INT_EDGE_NEG   = 3'd3,
      INT_EDGE_BOTH  = 3'd4
   } int_type_e;

   // per-pin configuration byte
   typedef struct packed {
      logic [2:0] int_type;
      logic       reserved;
      logic       int_en;
      logic       oe_en;
      logic       in_en;
      logic       out_en;
   } pin_cfg_t;

   // APB request side, as seen by the slave
   typedef struct packed {
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [APB_ADDR_W-1:0] paddr;
      logic [APB_DATA_W-1:0] pwdata;
   } apb_req_t;

   // write-one-to-clear request for the interrupt status
   typedef struct packed {
      logic              strobe;
      logic [MAX_IO-1:0] mask;
   } irq_clr_t;

endpackage

`default_nettype wire
